//--- include/pr_defs.svh
/*
 * Register file addresses and KI bus source select codes
 */
`ifndef PR_DEFS_SVH
`define PR_DEFS_SVH

localparam logic [2:0] R0_ADDR = 3'd0;	// Flags and user byte part
localparam logic [2:0] R1_ADDR = 3'd1;
localparam logic [2:0] R2_ADDR = 3'd2;
localparam logic [2:0] R3_ADDR = 3'd3;
localparam logic [2:0] R4_ADDR = 3'd4;
localparam logic [2:0] R5_ADDR = 3'd5;
localparam logic [2:0] R6_ADDR = 3'd6;
localparam logic [2:0] R7_ADDR = 3'd7;

localparam logic [1:0] KI_RZ  = 2'd0;	// Interrupt request word
localparam logic [1:0] KI_SYS = 2'd1;	// RS, BS, Q, NB packed together
localparam logic [1:0] KI_RB  = 2'd2;	// Binary load register
localparam logic [1:0] KI_ZP  = 2'd3;	// Interrupt mask word

`endif

//--- hdl/pr_pkg.sv
/*
 * Bus widths and CPU number, R0 flag and ALU status structs,
 * flag update enables, W bus word with its system control view
 */
package pr_pkg;

	`include "pr_defs.svh"

	localparam int word_w = 16;	// W, L and KI buses
	localparam int flag_w = 9;	// Z M V C L E G Y X
	localparam int nb_w   = 4;	// Memory block number
	localparam int rs_w   = 10;	// RS part of the KI bus

	localparam logic CPU_NUMBER = 1'b0;	// Jumper on 7-8

	// MSB first, so z lands on R0 bit 0
	typedef struct packed {
		logic z;	// Zero
		logic m;	// Minus
		logic v;	// Overflow, sticky
		logic c;	// Carry
		logic l;	// Less
		logic e;	// Equal
		logic g;	// Greater
		logic y;	// Shift extension
		logic x;	// Shift extension
	} r0_flags_t;

	typedef struct packed {
		logic zs;	// Result zero
		logic s0;	// Sign bit
		logic s_1;	// Bit beyond sign
		logic carry;
		logic aryt;	// Arithmetic compare
		logic ovf;
		logic exy;
		logic exx;
	} alu_stat_t;

	typedef struct packed {
		logic ust_z;
		logic ust_mc;
		logic ust_v;
		logic ust_leg;
		logic ust_y;
		logic ust_x;
	} flag_upd_t;

	// W bus as seen by the BAR load
	typedef struct packed {
		logic [0:word_w-nb_w-3] unused;	// Bits 0..9 ignored
		logic q;	// Bit 10
		logic bs;	// Bit 11
		logic [0:nb_w-1] nb;	// Bits 12..15
	} sys_word_t;

	typedef union packed {
		logic [0:word_w-1] raw;
		sys_word_t sys;
	} w_word_u;

endpackage

//--- hdl/pr_ctrl.sv
/*
 * Register address and strobe decode, R0 flag protection by Q,
 * blr override of all register reads
 */
`timescale 1ns/100ps

module pr_ctrl (
	input  logic [2:0] addr,	// Register address
	input  logic       rd,	// Read strobe, level
	input  logic       wr,	// Write strobe, one cycle
	input  logic       lpc,	// LPC instruction, full R0 load
	input  logic       blr,	// Register block, flags on L
	input  logic       q,	// System flag
	output logic       user_we,
	output logic       user_re,
	output logic       r0_we_user,
	output logic       r0_we_flags,
	output logic       r0_re,
	output logic       flags_shift_re
);

	import pr_pkg::*;

	logic r0_hit;	// Address points at R0
	logic rd_ok;	// Read not blocked
	logic wr_r0;	// Plain write to R0
	logic flags_open;	// Flag part writable by wr

	assign r0_hit = (addr == R0_ADDR);
	assign rd_ok  = rd & ~blr;	// blr wins over rd
	assign wr_r0  = wr & r0_hit;

	// User mode (q set) may touch only bits 9..15
	assign flags_open = ~q;

	// User register file
	assign user_we = wr & ~r0_hit;
	assign user_re = rd_ok & ~r0_hit;

	// R0, lpc loads both parts regardless of q
	assign r0_we_user  = wr_r0 | lpc;
	assign r0_we_flags = (wr_r0 & flags_open) | lpc;
	assign r0_re       = rd_ok & r0_hit;

	// Flags shifted into the low byte
	assign flags_shift_re = blr;

endmodule

//--- hdl/pr_user_regs.sv
/*
 * User registers R1..R7, one write port and one read port
 */
`timescale 1ns/100ps

module pr_user_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  pr_pkg::w_word_u           w,	// W bus
	input  logic [2:0]                addr,
	input  logic                      user_we,
	input  logic                      user_re,
	output logic [0:pr_pkg::word_w-1] rd_word	// Zero when not read
);

	import pr_pkg::*;

	logic [0:word_w-1] regs [1:7];	// R0 lives elsewhere

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (user_we) begin
			regs[addr] <= w.raw;	// addr never 0 here
		end
	end

	// Idle read gives zero so the L bus merge is a plain OR
	always_comb begin
		rd_word = '0;
		if (user_re) begin
			rd_word = regs[addr];
		end
	end

endmodule

//--- hdl/pr_r0_flags.sv
/*
 * R0 register: user byte part and Q-protected CPU flags,
 * flag updates from the ALU status on flag_stb
 */
`timescale 1ns/100ps

module pr_r0_flags (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             clm,	// Master clear
	input  pr_pkg::w_word_u                  w,
	input  logic                             r0_we_user,	// Bits 9..15
	input  logic                             r0_we_flags,	// Bits 0..8
	input  pr_pkg::alu_stat_t                alu,
	input  pr_pkg::flag_upd_t                upd,
	input  logic                             flag_stb,
	output pr_pkg::r0_flags_t                flags,
	output logic [0:pr_pkg::word_w-pr_pkg::flag_w-1] user_part
);

	import pr_pkg::*;

	r0_flags_t flags_upd;	// Flags after ALU update
	logic      stb_ok;	// Update not overridden by a write

	// Any R0 write in this cycle beats the ALU
	assign stb_ok = flag_stb & ~r0_we_user & ~r0_we_flags;

	always_comb begin
		flags_upd = flags;
		if (upd.ust_z) begin
			flags_upd.z = alu.zs;
		end
		if (upd.ust_mc) begin
			flags_upd.m = alu.s0;
			flags_upd.c = alu.carry;
		end
		if (upd.ust_v) begin
			flags_upd.v = flags.v | alu.ovf;	// Sticky until cleared
		end
		if (upd.ust_leg) begin
			flags_upd.e = alu.zs;
			flags_upd.l = alu.aryt ? alu.s_1 : alu.carry;	// Signed vs unsigned
			flags_upd.g = ~flags_upd.l & ~alu.zs;
		end
		if (upd.ust_y) begin
			flags_upd.y = alu.exy;
		end
		if (upd.ust_x) begin
			flags_upd.x = alu.exx;
		end
	end

	// User part, no protection
	always_ff @(posedge clk) begin
		if (rst || clm) begin
			user_part <= '0;
		end else if (r0_we_user) begin
			user_part <= w.raw[flag_w:word_w-1];
		end
	end

	// Flag part
	always_ff @(posedge clk) begin
		if (rst || clm) begin
			flags <= '0;
		end else if (r0_we_flags) begin
			flags <= w.raw[0:flag_w-1];
		end else if (stb_ok) begin
			flags <= flags_upd;
		end
	end

endmodule

//--- hdl/pr_sys_regs.sv
/*
 * Q, BS, NB system registers and binary load register RB,
 * NB, PN and Q system bus drivers
 */
`timescale 1ns/100ps

module pr_sys_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      clm,
	input  pr_pkg::w_word_u           w,
	input  logic                      w_bar,	// W to Q, BS, NB
	input  logic                      w_rba,	// RB bits 10..15
	input  logic                      w_rbb,	// RB bits 4..9
	input  logic                      w_rbc,	// RB bits 0..3
	input  logic                      bar_nb,	// Put NB on system bus
	input  logic                      q_nb,
	input  logic                      bp_nb,
	input  logic                      pn_nb,
	input  logic                      rpn,
	output logic                      q,
	output logic                      bs,
	output logic [0:pr_pkg::nb_w-1]   nb,
	output logic [0:pr_pkg::word_w-1] rb,
	output logic [0:pr_pkg::nb_w-1]   dnb,
	output logic                      dpn,
	output logic                      dqb,
	output logic                      zgpn
);

	import pr_pkg::*;

	// Q, BS, NB, loaded together from the sys view
	always_ff @(posedge clk) begin
		if (rst || clm) begin
			q  <= 1'b0;
			bs <= 1'b0;
			nb <= '0;
		end else if (w_bar) begin
			q  <= w.sys.q;
			bs <= w.sys.bs;
			nb <= w.sys.nb;
		end
	end

	// RB loads from the low end of W, clm leaves it alone
	always_ff @(posedge clk) begin
		if (rst) begin
			rb <= '0;
		end else begin
			if (w_rbc)
				rb[0:3] <= w.raw[12:15];	// 4 bits
			if (w_rbb)
				rb[4:9] <= w.raw[10:15];	// 6 bits
			if (w_rba)
				rb[10:15] <= w.raw[10:15];	// 6 bits
		end
	end

	assign dnb  = bar_nb ? nb : '0;
	assign dqb  = q & q_nb;
	assign dpn  = ((bs ^ CPU_NUMBER) & bp_nb) | (CPU_NUMBER & pn_nb);	// Block select
	assign zgpn = rpn ^ CPU_NUMBER;	// Request aimed at this CPU

endmodule

//--- hdl/pr_bus_mux.sv
/*
 * L bus merge of user registers and R0, KI bus source select
 */
`timescale 1ns/100ps

module pr_bus_mux (
	input  logic [0:pr_pkg::word_w-1]                rd_word,	// Zero when idle
	input  pr_pkg::r0_flags_t                        flags,
	input  logic [0:pr_pkg::word_w-pr_pkg::flag_w-1] user_part,
	input  logic                                     r0_re,
	input  logic                                     flags_shift_re,
	input  logic [1:0]                               ki_sel,
	input  logic [0:pr_pkg::word_w-1]                rz,
	input  logic [0:pr_pkg::word_w-1]                zp,
	input  logic [0:pr_pkg::rs_w-1]                  rs,
	input  logic                                     bs,
	input  logic                                     q,
	input  logic [0:pr_pkg::nb_w-1]                  nb,
	input  logic [0:pr_pkg::word_w-1]                rb,
	output logic [0:pr_pkg::word_w-1]                l,
	output logic [0:pr_pkg::word_w-1]                ki
);

	import pr_pkg::*;

	logic [0:word_w-1] l_r0;	// Whole R0 word
	logic [0:word_w-1] l_shift;	// Z..Y moved to bits 8..15
	logic [0:flag_w-1] flag_bits;

	assign flag_bits = flags;
	assign l_r0    = r0_re ? {flag_bits, user_part} : '0;
	assign l_shift = flags_shift_re ? {8'h00, flag_bits[0:7]} : '0;

	// At most one source is live, the rest read as zero
	assign l = rd_word | l_r0 | l_shift;

	always_comb begin
		case (ki_sel)
			KI_RZ:   ki = rz;
			KI_SYS:  ki = {rs, bs, q, nb};	// 10 + 1 + 1 + 4
			KI_RB:   ki = rb;
			KI_ZP:   ki = zp;
			default: ki = zp;
		endcase
	end

endmodule

//--- hdl/pr.sv
/*
 * Register unit top: decode, user registers, R0, system registers
 * and bus merge
 */
`timescale 1ns/100ps

module pr (
	input  logic                      clk,
	input  logic                      rst,
	input  pr_pkg::w_word_u           w,	// W bus
	input  logic [2:0]                addr,
	input  logic                      rd,
	input  logic                      wr,
	input  logic                      lpc,
	input  logic                      blr,
	input  logic                      w_bar,
	input  logic                      clm,
	input  logic                      w_rba,
	input  logic                      w_rbb,
	input  logic                      w_rbc,
	input  pr_pkg::alu_stat_t         alu,
	input  pr_pkg::flag_upd_t         upd,
	input  logic                      flag_stb,
	input  logic [1:0]                ki_sel,
	input  logic [0:pr_pkg::word_w-1] rz,
	input  logic [0:pr_pkg::word_w-1] zp,
	input  logic [0:pr_pkg::rs_w-1]   rs,
	input  logic                      bar_nb,
	input  logic                      q_nb,
	input  logic                      bp_nb,
	input  logic                      pn_nb,
	input  logic                      rpn,
	output logic [0:pr_pkg::word_w-1] l,	// Internal L bus
	output logic [0:pr_pkg::word_w-1] ki,	// KI bus
	output pr_pkg::r0_flags_t         r0,	// CPU flags
	output logic                      q,
	output logic [0:pr_pkg::nb_w-1]   dnb,
	output logic                      dpn,
	output logic                      dqb,
	output logic                      zgpn
);

	import pr_pkg::*;

	logic user_we, user_re;
	logic r0_we_user, r0_we_flags, r0_re;
	logic flags_shift_re;
	logic bs;
	logic [0:nb_w-1] nb;
	logic [0:word_w-1] rb;
	logic [0:word_w-1] rd_word;	// User register read
	logic [0:word_w-flag_w-1] user_part;	// R0 bits 9..15

	pr_ctrl u_ctrl (
		.addr(addr), .rd(rd), .wr(wr), .lpc(lpc), .blr(blr), .q(q),
		.user_we(user_we), .user_re(user_re),
		.r0_we_user(r0_we_user), .r0_we_flags(r0_we_flags), .r0_re(r0_re),
		.flags_shift_re(flags_shift_re)
	);

	pr_user_regs u_user_regs (
		.clk(clk), .rst(rst), .w(w), .addr(addr),
		.user_we(user_we), .user_re(user_re), .rd_word(rd_word)
	);

	pr_r0_flags u_r0_flags (
		.clk(clk), .rst(rst), .clm(clm), .w(w),
		.r0_we_user(r0_we_user), .r0_we_flags(r0_we_flags),
		.alu(alu), .upd(upd), .flag_stb(flag_stb),
		.flags(r0), .user_part(user_part)
	);

	pr_sys_regs u_sys_regs (
		.clk(clk), .rst(rst), .clm(clm), .w(w), .w_bar(w_bar),
		.w_rba(w_rba), .w_rbb(w_rbb), .w_rbc(w_rbc),
		.bar_nb(bar_nb), .q_nb(q_nb), .bp_nb(bp_nb), .pn_nb(pn_nb), .rpn(rpn),
		.q(q), .bs(bs), .nb(nb), .rb(rb),
		.dnb(dnb), .dpn(dpn), .dqb(dqb), .zgpn(zgpn)
	);

	pr_bus_mux u_bus_mux (
		.rd_word(rd_word), .flags(r0), .user_part(user_part),
		.r0_re(r0_re), .flags_shift_re(flags_shift_re),
		.ki_sel(ki_sel), .rz(rz), .zp(zp), .rs(rs),
		.bs(bs), .q(q), .nb(nb), .rb(rb),
		.l(l), .ki(ki)
	);

endmodule

//--- dv/pr_tb_clk.sv
/*
 * Free running testbench clock, 4 ns period
 */
`timescale 1ns/100ps

module pr_tb_clk (
	output logic clk
);

	initial clk = 1'b0;	// Known level before first edge

	always #2 clk = ~clk;	// Half period

endmodule

//--- dv/pr_assertions.sv
/*
 * Concurrent checks on the register unit: NB driver idle,
 * L bus idle, Q cleared by clm
 */
`timescale 1ns/100ps

module pr_assertions (
	input logic                      clk,
	input logic                      rst,
	input logic                      clm,
	input logic                      rd,
	input logic                      blr,
	input logic                      bar_nb,
	input logic                      q,
	input logic [0:pr_pkg::nb_w-1]   dnb,
	input logic [0:pr_pkg::word_w-1] l
);

	a_dnb_idle: assert property (@(posedge clk) disable iff (rst)
		!bar_nb |-> dnb == '0)
		else $error("dnb driven while bar_nb is low");

	a_l_idle: assert property (@(posedge clk) disable iff (rst)
		(!rd && !blr) |-> l == '0)	// No read source live
		else $error("l not zero with no read active");

	a_q_clm: assert property (@(posedge clk) disable iff (rst)
		clm |=> !q)
		else $error("q still set the cycle after clm");

endmodule

bind pr pr_assertions u_pr_assertions (
	.clk(clk), .rst(rst), .clm(clm), .rd(rd), .blr(blr),
	.bar_nb(bar_nb), .q(q), .dnb(dnb), .l(l)
);

//--- dv/pr_tb.sv
/*
 * Register unit testbench with a step table built by a reference model,
 * applied in a loop with compare tasks and a watchdog
 */
`timescale 1ns/100ps

module pr_tb;

	import pr_pkg::*;

	typedef enum logic [3:0] {OP_WR, OP_LPC, OP_BAR, OP_CLM, OP_RB, OP_FLAG, OP_RD,
		OP_BLR, OP_IDLE, OP_R0, OP_KI, OP_DRV} op_t;

	typedef struct packed {
		op_t               op;
		logic [2:0]        addr;	// Register, RB part or KI code
		logic [0:word_w-1] data;
		logic [0:word_w-1] exp;	// From the model
	} step_t;

	logic clk, rst, wr, rd, lpc, blr, w_bar, clm, w_rba, w_rbb, w_rbc, flag_stb;
	logic bar_nb, q_nb, bp_nb, pn_nb, rpn, q, dpn, dqb, zgpn;
	logic [2:0] addr;
	logic [1:0] ki_sel;
	logic [0:word_w-1] rz, zp, l, ki;
	logic [0:rs_w-1] rs;
	logic [0:nb_w-1] dnb;
	w_word_u w;
	alu_stat_t alu;
	flag_upd_t upd;
	r0_flags_t r0;

	step_t steps[$];
	logic table_ready = 1'b0;
	logic [0:word_w-1] m_ur [1:7];	// Model state
	logic [0:word_w-1] m_r0, m_rb;
	logic m_q, m_bs;
	logic [0:nb_w-1] m_nb;

	pr_tb_clk u_clk (.clk(clk));

	pr u_pr (.*);

	function automatic logic [0:word_w-1] rand_word();
		return 16'($urandom);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input logic [0:word_w-1] got, exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
	endtask

	task automatic check_flags(input string name, input r0_flags_t got, exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
	endtask

	// Model one step and store its expectation
	task automatic add_step(input op_t op, input logic [2:0] a, input logic [0:word_w-1] d);
		logic [0:flag_w-1] f;
		logic [0:word_w-1] e;
		e = '0;
		f = m_r0[0:flag_w-1];	// Z M V C L E G Y X
		case (op)
			OP_WR: begin
				if (a != R0_ADDR) begin
					m_ur[a] = d;
				end else begin
					m_r0[9:15] = d[9:15];
					if (!m_q)
						m_r0[0:8] = d[0:8];	// Flags open only with q clear
				end
			end
			OP_LPC: m_r0 = d;
			OP_BAR: {m_q, m_bs, m_nb} = d[10:15];
			OP_CLM: {m_q, m_bs, m_nb, m_r0} = '0;
			OP_RB: begin
				if (a == 0)
					m_rb[0:3] = d[12:15];
				else if (a == 1)
					m_rb[4:9] = d[10:15];
				else
					m_rb[10:15] = d[10:15];
			end
			OP_FLAG: begin	// alu in d[0:7] and enables in d[8:13]
				if (d[8])
					f[0] = d[0];
				if (d[9])
					{f[1], f[3]} = {d[1], d[3]};
				if (d[10])
					f[2] = f[2] | d[5];	// Sticky V
				if (d[11]) begin
					f[5] = d[0];
					f[4] = d[4] ? d[2] : d[3];
					f[6] = ~f[4] & ~d[0];
				end
				if (d[12])
					f[7] = d[6];
				if (d[13])
					f[8] = d[7];
				m_r0[0:8] = f;
			end
			OP_RD: e = (a == R0_ADDR) ? m_r0 : m_ur[a];
			OP_BLR: e = {8'h00, m_r0[0:7]};
			OP_R0: e[0:8] = m_r0[0:8];
			OP_KI: begin
				case (a[1:0])
					KI_RZ:   e = d;
					KI_SYS:  e = {d[6:15], m_bs, m_q, m_nb};
					KI_RB:   e = m_rb;
					default: e = ~d;	// zp is driven as ~data
				endcase
			end
			OP_DRV: e = {8'h00, m_q, d[11] ? m_nb : 4'h0, m_q & d[12],
				((m_bs ^ CPU_NUMBER) & d[13]) | (CPU_NUMBER & d[14]), d[15] ^ CPU_NUMBER};
			default: e = '0;	// Idle L bus
		endcase
		steps.push_back('{op, a, d, e});
	endtask

	task automatic flag_step(input logic [0:7] a, input logic [0:5] u);
		add_step(OP_FLAG, 3'd0, {a, u, 2'b00});
		add_step(OP_R0, 3'd0, '0);
		add_step(OP_BLR, 3'($urandom), '0);	// rd also high but blr wins
	endtask

	task automatic build_table();
		logic [0:word_w-1] d;
		logic [0:7] a;
		{m_r0, m_rb, m_q, m_bs, m_nb} = '0;
		foreach (m_ur[i])
			m_ur[i] = '0;
		for (int i = 1; i < 8; i++)
			add_step(OP_WR, i[2:0], rand_word());
		for (int i = 1; i < 8; i++)
			add_step(OP_RD, i[2:0], '0);
		add_step(OP_IDLE, 3'd0, '0);
		add_step(OP_WR, R0_ADDR, rand_word());	// Whole word while q is clear
		add_step(OP_R0, 3'd0, '0);
		add_step(OP_RD, R0_ADDR, '0);
		d = rand_word();
		d[10] = 1'b1;
		add_step(OP_BAR, 3'd0, d);
		add_step(OP_WR, R0_ADDR, rand_word());	// Flags protected now
		add_step(OP_RD, R0_ADDR, '0);
		add_step(OP_LPC, 3'd0, rand_word());
		add_step(OP_RD, R0_ADDR, '0);
		add_step(OP_LPC, 3'd0, '0);
		flag_step(8'($urandom), 6'b100000);
		flag_step(8'($urandom), 6'b010000);
		a = 8'($urandom);
		a[5] = 1'b1;
		flag_step(a, 6'b001000);
		a[5] = 1'b0;
		flag_step(a, 6'b001000);	// V must hold
		for (int k = 0; k < 4; k++) begin
			a = 8'($urandom);
			a[4] = k[0];	// Both compare modes
			a[2] = k[1];	// s_1 and carry differ so aryt matters
			a[3] = ~k[1];
			flag_step(a, 6'b000100);
		end
		flag_step(8'($urandom), 6'b000011);
		flag_step(8'($urandom), 6'b111111);
		for (int k = 0; k < 4; k++) begin
			d = rand_word();
			d[10:11] = k[1:0];	// Last pass leaves q and bs set
			add_step(OP_BAR, 3'd0, d);
			for (int j = 0; j < 3; j++) begin
				d = rand_word();
				if (j == 0)
					d[11:15] = 5'h1f;	// All drivers enabled
				else if (j == 1)
					d[11:15] = 5'h00;	// All drivers off
				add_step(OP_DRV, 3'd0, d);
			end
		end
		for (int k = 0; k < 3; k++)
			add_step(OP_RB, k[2:0], rand_word());
		for (int k = 0; k < 8; k++)
			add_step(OP_KI, k[2:0], rand_word());
		add_step(OP_CLM, 3'd0, '0);
		add_step(OP_R0, 3'd0, '0);
		add_step(OP_RD, R0_ADDR, '0);
		add_step(OP_DRV, 3'd0, 16'hffff);
		add_step(OP_KI, {1'b0, KI_SYS}, rand_word());
		add_step(OP_KI, {1'b0, KI_RB}, rand_word());
		for (int i = 1; i < 8; i++)
			add_step(OP_RD, i[2:0], '0);
	endtask

	task automatic apply_step(input step_t s);
		@(posedge clk);
		{wr, rd, lpc, blr, w_bar, clm, w_rba, w_rbb, w_rbc, flag_stb} <= '0;
		addr <= s.addr;
		w.raw <= s.data;
		case (s.op)
			OP_WR:   wr <= 1'b1;
			OP_LPC:  lpc <= 1'b1;
			OP_BAR:  w_bar <= 1'b1;
			OP_CLM:  clm <= 1'b1;
			OP_RB:   {w_rba, w_rbb, w_rbc} <= 3'b001 << s.addr;
			OP_FLAG: {flag_stb, alu, upd} <= {1'b1, s.data[0:13]};
			OP_RD:   rd <= 1'b1;
			OP_BLR:  {blr, rd} <= 2'b11;
			OP_KI:   {ki_sel, rz, zp, rs} <= {s.addr[1:0], s.data, ~s.data, s.data[6:15]};
			OP_DRV:  {bar_nb, q_nb, bp_nb, pn_nb, rpn} <= s.data[11:15];
			default: ;
		endcase
		@(negedge clk);	// Outputs settled
		case (s.op)
			OP_RD, OP_BLR, OP_IDLE: check_word("l", l, s.exp);
			OP_R0: check_flags("r0", r0, s.exp[0:8]);
			OP_KI: check_word("ki", ki, s.exp);
			OP_DRV: begin
				check_bit("q", q, s.exp[8]);
				check_word("dnb", {12'h000, dnb}, {12'h000, s.exp[9:12]});
				check_bit("dqb", dqb, s.exp[13]);
				check_bit("dpn", dpn, s.exp[14]);
				check_bit("zgpn", zgpn, s.exp[15]);
			end
			default: ;
		endcase
	endtask

	initial begin
		void'($urandom(32'h36670df2));
		rst = 1'b1;
		{wr, rd, lpc, blr, w_bar, clm, w_rba, w_rbb, w_rbc, flag_stb} = '0;
		{bar_nb, q_nb, bp_nb, pn_nb, rpn} = '0;
		{addr, ki_sel, rz, zp, rs} = '0;
		w = '0;
		alu = '0;
		upd = '0;
		build_table();
		table_ready = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		foreach (steps[i])
			apply_step(steps[i]);
		$display("STATUS: PASS");
		$finish;
	end

	// Ten cycles per step plus reset
	initial begin
		wait (table_ready);
		repeat (steps.size() * 10 + 16) @(posedge clk);
		abort_run("watchdog expired before the step table was done");
	end

endmodule

//--- src.f
+incdir+include
hdl/pr_pkg.sv
hdl/pr_ctrl.sv
hdl/pr_user_regs.sv
hdl/pr_r0_flags.sv
hdl/pr_sys_regs.sv
hdl/pr_bus_mux.sv
hdl/pr.sv
dv/pr_tb_clk.sv
dv/pr_assertions.sv
dv/pr_tb.sv

//--- Bender.yml
package:
  name: pr

sources:
  - include_dirs:
      - include
    files:
      - hdl/pr_pkg.sv
      - hdl/pr_ctrl.sv
      - hdl/pr_user_regs.sv
      - hdl/pr_r0_flags.sv
      - hdl/pr_sys_regs.sv
      - hdl/pr_bus_mux.sv
      - hdl/pr.sv
  - target: test
    files:
      - dv/pr_tb_clk.sv
      - dv/pr_assertions.sv
      - dv/pr_tb.sv
